//--- list.f
+incdir+.
tx_engine_pkg.sv
tx_ctrl_datap_if.sv
send_q_fifo.sv
tx_app_state_mem.sv
tx_copy_counter.sv
tx_engine_ctrl.sv
tx_engine_datap.sv
tx_engine_top.sv
tb_tx_engine.sv

//--- send_q_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_engine_macros.svh"

module send_q_fifo
    import tx_engine_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         wr_req,
    input  send_q_struct wr_data,
    output logic         full,
    input  logic         rd_req,
    output send_q_struct rd_data,
    output logic         empty
);

    localparam int ptr_w = $clog2(`SEND_Q_DEPTH);
    localparam int cnt_w = $clog2(`SEND_Q_DEPTH + 1);

    send_q_struct mem [`SEND_Q_DEPTH];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    always_ff @(posedge clk) begin
        if (wr_req) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_req) begin
                wr_ptr <= (wr_ptr == ptr_w'(`SEND_Q_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_req) begin
                rd_ptr <= (rd_ptr == ptr_w'(`SEND_Q_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(wr_req) - cnt_w'(rd_req);
        end
    end

    // Head entry shown directly
    assign rd_data = mem[rd_ptr];
    assign full    = (count == cnt_w'(`SEND_Q_DEPTH));
    assign empty   = (count == '0);

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_req |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_req |-> !empty);

endmodule

`default_nettype wire

//--- tb_tx_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_engine_macros.svh"

module tb_tx_engine
    import tx_engine_pkg::*;
();

    logic                  clk;
    logic                  rst;
    logic                  cmd_val;
    send_q_struct          cmd_data;
    logic                  cmd_rdy;
    logic                  setup_val;
    logic [`FLOW_ID_W-1:0] setup_flowid;
    logic [`PKT_W-1:0]     setup_pkts;
    logic                  setup_done;
    logic                  ptr_req_val;
    ptr_req_struct         ptr_req_data;
    logic                  ptr_req_rdy;
    logic                  notif_val;
    logic [`ADDR_W-1:0]    notif_addr;
    flag_e                 notif_copy;
    logic                  notif_rdy;
    logic                  buf_req_val;
    logic [`ADDR_W-1:0]    buf_req_addr;
    logic [`LEN_W-1:0]     buf_req_len;
    logic                  buf_req_rdy;
    logic                  buf_data_val;
    logic [`DATA_W-1:0]    buf_data;
    logic                  buf_data_rdy;
    logic                  buf_done;
    logic                  buf_done_rdy;

    logic [31:0]        pat_mem [0:63];
    send_q_struct       cmd_list [$];
    send_q_struct       model_q [$];
    logic [31:0]        setup_list [$];
    logic [31:0]        notif_list [$];
    int                 bench_left [`NUM_FLOWS];
    int                 exp_updates;
    int                 ptr_updates;
    int                 cycle_count = 0;
    int                 cycle_limit = 500;
    integer             seed;
    send_q_struct       cur_cmd;
    logic [`LEN_W-1:0]  cur_len;
    logic [`ADDR_W-1:0] cur_addr;
    logic               msg_open;
    logic               exp_copy;
    logic               buf_req_seen;
    logic               notif_due;
    logic               notif_taken;
    int                 beats;
    int                 done_count;
    logic               hold_ptr;
    logic               hold_req;
    logic               hold_data;
    ptr_req_struct      last_ptr;
    logic [63:0]        last_req;
    logic [`DATA_W-1:0] last_data;

    tx_engine_top UUT (
        .clk(clk), .rst(rst),
        .cmd_val(cmd_val), .cmd_data(cmd_data), .cmd_rdy(cmd_rdy),
        .setup_val(setup_val), .setup_flowid(setup_flowid), .setup_pkts(setup_pkts),
        .setup_done(setup_done),
        .ptr_req_val(ptr_req_val), .ptr_req_data(ptr_req_data), .ptr_req_rdy(ptr_req_rdy),
        .notif_val(notif_val), .notif_addr(notif_addr), .notif_copy(notif_copy),
        .notif_rdy(notif_rdy),
        .buf_req_val(buf_req_val), .buf_req_addr(buf_req_addr), .buf_req_len(buf_req_len),
        .buf_req_rdy(buf_req_rdy),
        .buf_data_val(buf_data_val), .buf_data(buf_data), .buf_data_rdy(buf_data_rdy),
        .buf_done(buf_done), .buf_done_rdy(buf_done_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic load_patterns();
        logic [31:0] w;
        logic        found_end;
        $readmemh("tx_engine_patterns.txt", pat_mem);
        found_end = 1'b0;
        for (int i = 0; i < 64 && !found_end; i++) begin
            w = pat_mem[i];
            case (w[31:28])
                4'h1: setup_list.push_back(w);
                4'h2: cmd_list.push_back('{cmd: cmd_e'(w[20]), flowid: w[17:16],
                                          length: w[15:0]});
                4'h3: notif_list.push_back(w);
                4'hf: begin
                    exp_updates = w[15:0];
                    found_end   = 1'b1;
                end
                default: report_failure("Patterns file has an unknown or missing line");
            endcase
        end
        if (!found_end) begin
            report_failure("Patterns file has no expected-count line");
        end
    endtask

    task automatic push_command(input send_q_struct c);
        cmd_val  = 1'b1;
        cmd_data = c;
        @(negedge clk);
        while (!cmd_rdy) @(negedge clk);
        @(posedge clk);
        #1;
        cmd_val = 1'b0;
    endtask

    // Model queue follows the same re-enqueue order as the engine
    task automatic start_message();
        if (model_q.size() == 0) begin
            report_failure("Message request arrived with no command left to send");
        end else begin
            cur_cmd = model_q.pop_front();
            cur_len = (cur_cmd.cmd == BENCH) ? `LEN_W'(`BENCH_PKT_BYTES) : cur_cmd.length;
            check_value("msg_req flowid", cur_cmd.flowid, ptr_req_data.flowid);
            check_value("msg_req length", cur_len, ptr_req_data.length);
            if (cur_cmd.cmd == BENCH) begin
                bench_left[cur_cmd.flowid]--;
                if (bench_left[cur_cmd.flowid] > 0) begin
                    model_q.push_back(cur_cmd);
                end
            end
            msg_open     = 1'b1;
            notif_due    = 1'b1;
            exp_copy     = 1'b0;
            buf_req_seen = 1'b0;
            beats        = 0;
        end
    endtask

    task automatic finish_message();
        check_value("ptr_update flowid", cur_cmd.flowid, ptr_req_data.flowid);
        check_value("ptr_update length", cur_len, ptr_req_data.length);
        check_value("data beats", exp_copy ? cur_len / 4 : 0, beats);
        msg_open = 1'b0;
        ptr_updates++;
    endtask

    task automatic check_holds();
        if (hold_ptr) begin
            check_value("ptr_req_val held", 1, ptr_req_val);
            check_value("ptr_req_data held", last_ptr, ptr_req_data);
        end
        if (hold_req) begin
            check_value("buf_req_val held", 1, buf_req_val);
            check_value("buf_req fields held", last_req, {buf_req_addr, buf_req_len});
        end
        if (hold_data) begin
            check_value("buf_data_val held", 1, buf_data_val);
            check_value("buf_data held", last_data, buf_data);
        end
        hold_ptr  = ptr_req_val && !ptr_req_rdy;
        hold_req  = buf_req_val && !buf_req_rdy;
        hold_data = buf_data_val && !buf_data_rdy;
        last_ptr  = ptr_req_data;
        last_req  = {buf_req_addr, buf_req_len};
        last_data = buf_data;
    endtask

    task automatic observe_handshakes();
        if (ptr_req_val && ptr_req_rdy) begin
            check_value("ptr_req kind", msg_open ? PTR_UPDATE : MSG_REQ, ptr_req_data.kind);
            if (msg_open) begin
                finish_message();
            end else begin
                start_message();
            end
        end
        if (notif_val && notif_rdy) begin
            cur_addr    = notif_addr;
            exp_copy    = (cur_cmd.cmd == SINGLE) || (notif_copy == TRUE);
            notif_taken = 1'b1;
        end
        if (buf_req_val && buf_req_rdy) begin
            check_value("buf_req only when copying", 1, exp_copy && !buf_req_seen);
            check_value("buf_req_addr", cur_addr, buf_req_addr);
            check_value("buf_req_len", cur_len, buf_req_len);
            buf_req_seen = 1'b1;
        end
        if (buf_data_val && buf_data_rdy) begin
            check_value("buf_req before data", 1, buf_req_seen);
            check_value("buf_data", (32'(cur_cmd.flowid) << 24) + 32'(beats * 4), buf_data);
            beats++;
            if (beats == cur_len / 4) begin
                done_count = 2;
            end
        end
        if (buf_done) begin
            check_value("buf_done_rdy at done pulse", 1, buf_done_rdy);
        end
    endtask

    // Buffer manager side of one clock cycle
    task automatic service_cycle();
        logic [31:0] rnd;
        logic [31:0] n;
        @(posedge clk);
        #1;
        rnd          = $random(seed);
        ptr_req_rdy  = rnd[0];
        buf_req_rdy  = rnd[1];
        buf_data_rdy = rnd[2] | rnd[3];
        if (notif_taken) begin
            notif_val   = 1'b0;
            notif_taken = 1'b0;
        end
        if (notif_due) begin
            if (notif_list.size() == 0) begin
                report_failure("Patterns file has too few notification lines");
            end else begin
                n          = notif_list.pop_front();
                notif_val  = 1'b1;
                notif_addr = n[23:0];
                notif_copy = flag_e'(n[24]);
                notif_due  = 1'b0;
            end
        end
        buf_done = 1'b0;
        if (done_count > 0) begin
            done_count--;
            if (done_count == 0) begin
                buf_done = 1'b1;
            end
        end
        @(negedge clk);
        check_holds();
        observe_handshakes();
    endtask

    initial begin
        logic [31:0] w;
        seed         = 32'h1ab2_b0b7;
        rst          = 1'b1;
        cmd_val      = 1'b0;
        cmd_data     = '0;
        setup_val    = 1'b0;
        setup_flowid = '0;
        setup_pkts   = '0;
        setup_done   = 1'b0;
        ptr_req_rdy  = 1'b0;
        notif_val    = 1'b0;
        notif_addr   = '0;
        notif_copy   = FALSE;
        buf_req_rdy  = 1'b0;
        buf_data_rdy = 1'b0;
        buf_done     = 1'b0;
        msg_open     = 1'b0;
        exp_copy     = 1'b0;
        buf_req_seen = 1'b0;
        notif_due    = 1'b0;
        notif_taken  = 1'b0;
        hold_ptr     = 1'b0;
        hold_req     = 1'b0;
        hold_data    = 1'b0;
        beats        = 0;
        done_count   = 0;
        ptr_updates  = 0;
        exp_updates  = 0;
        foreach (bench_left[i]) bench_left[i] = 0;

        load_patterns();
        cycle_limit = 200 * exp_updates + 500;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("reset ptr_req_val", 0, ptr_req_val);
        check_value("reset notif_rdy", 0, notif_rdy);
        check_value("reset buf_req_val", 0, buf_req_val);
        check_value("reset buf_data_val", 0, buf_data_val);
        check_value("reset buf_done_rdy", 0, buf_done_rdy);
        check_value("reset cmd_rdy", 1, cmd_rdy);
        @(posedge clk);
        #1;

        foreach (cmd_list[i]) begin
            push_command(cmd_list[i]);
            model_q.push_back(cmd_list[i]);
        end

        // BENCH at the head is held back while setup_done is low
        repeat (20) begin
            @(negedge clk);
            check_value("msg_req before setup_done", 0, ptr_req_val);
        end
        @(posedge clk);
        #1;
        foreach (setup_list[i]) begin
            w            = setup_list[i];
            setup_val    = 1'b1;
            setup_flowid = w[17:16];
            setup_pkts   = w[15:0];
            bench_left[w[17:16]] = w[15:0];
            @(posedge clk);
            #1;
        end
        setup_val  = 1'b0;
        setup_done = 1'b1;

        while (ptr_updates < exp_updates) service_cycle();

        repeat (50) begin
            @(negedge clk);
            check_value("no request after last update", 0, ptr_req_val);
        end
        check_value("commands left in model", 0, model_q.size());
        check_value("unused notifications", 0, notif_list.size());
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tx_app_state_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_engine_macros.svh"

module tx_app_state_mem (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  setup_val,
    input  logic [`FLOW_ID_W-1:0] setup_flowid,
    input  logic [`PKT_W-1:0]     setup_pkts,
    input  logic                  rd_req,
    input  logic [`FLOW_ID_W-1:0] rd_flowid,
    output logic [`PKT_W-1:0]     rd_pkts,
    input  logic                  wr_req,
    input  logic [`FLOW_ID_W-1:0] wr_flowid,
    input  logic [`PKT_W-1:0]     wr_pkts
);

    logic [`PKT_W-1:0] pkts_left [`NUM_FLOWS];

    // Engine writes win over setup writes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_FLOWS; i++) begin
                pkts_left[i] <= '0;
            end
        end else if (wr_req) begin
            pkts_left[wr_flowid] <= wr_pkts;
        end else if (setup_val) begin
            pkts_left[setup_flowid] <= setup_pkts;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_pkts <= pkts_left[rd_flowid];
        end
    end

endmodule

`default_nettype wire

//--- tx_copy_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_engine_macros.svh"

module tx_copy_counter (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_len,
    input  logic [`LEN_W-1:0] len,
    input  logic              decr,
    output logic              last_wr,
    output logic [`LEN_W-1:0] offset
);

    logic [`LEN_W-1:0] bytes_left;

    always_ff @(posedge clk) begin
        if (rst) begin
            bytes_left <= '0;
            offset     <= '0;
        end else if (load_len) begin
            bytes_left <= len;
            offset     <= '0;
        end else if (decr) begin
            // One 4-byte word per beat
            bytes_left <= bytes_left - `LEN_W'(4);
            offset     <= offset + `LEN_W'(4);
        end
    end

    assign last_wr = (bytes_left <= `LEN_W'(4));

    // Copy must never run past the loaded length
    a_no_decr_at_zero: assert property (
        @(posedge clk) disable iff (rst) decr |-> (bytes_left != '0)
    );

endmodule

`default_nettype wire

//--- tx_ctrl_datap_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tx_ctrl_datap_if
    import tx_engine_pkg::*;
();

    logic      store_inputs;
    logic      store_app_state;
    logic      store_notif;
    ptr_kind_e out_mux_sel;

    logic      last_pkt;
    flag_e     should_copy;
    cmd_e      cur_cmd;

    modport ctrl (
        output store_inputs, store_app_state, store_notif, out_mux_sel,
        input  last_pkt, should_copy, cur_cmd
    );

    modport datap (
        input  store_inputs, store_app_state, store_notif, out_mux_sel,
        output last_pkt, should_copy, cur_cmd
    );

endinterface

`default_nettype wire

//--- tx_engine_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tx_engine_ctrl
    import tx_engine_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            send_q_empty,
    input  send_q_struct    send_q_rd_data,
    output logic            send_q_rd_req,
    output logic            send_q_wr_req,
    input  logic            setup_done,
    output logic            ptr_req_val,
    input  logic            ptr_req_rdy,
    input  logic            notif_val,
    output logic            notif_rdy,
    output logic            buf_req_val,
    input  logic            buf_req_rdy,
    output logic            buf_data_val,
    input  logic            buf_data_rdy,
    input  logic            buf_done,
    output logic            buf_done_rdy,
    output logic            state_rd_req,
    output logic            state_wr_req,
    output logic            load_len,
    output logic            decr,
    input  logic            last_wr,
    tx_ctrl_datap_if.ctrl   dp
);

    typedef enum logic [3:0] {
        READY,
        RD_APP_STATE,
        WAIT_APP_STATE,
        TX_MSG_REQ,
        TX_MSG_NOTIF,
        TX_WR_MEM_REQ,
        PAYLOAD_COPY,
        WAIT_WR_RESP,
        BUMP_TAIL,
        UPDATE_FLOW
    } state_e;

    state_e state_reg;
    state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= READY;
        end else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        send_q_rd_req      = 1'b0;
        send_q_wr_req      = 1'b0;
        ptr_req_val        = 1'b0;
        notif_rdy          = 1'b0;
        buf_req_val        = 1'b0;
        buf_data_val       = 1'b0;
        buf_done_rdy       = 1'b0;
        state_rd_req       = 1'b0;
        state_wr_req       = 1'b0;
        load_len           = 1'b0;
        decr               = 1'b0;
        dp.store_inputs    = 1'b0;
        dp.store_app_state = 1'b0;
        dp.store_notif     = 1'b0;
        dp.out_mux_sel     = MSG_REQ;
        state_next         = state_reg;

        case (state_reg)
            READY: begin
                // BENCH waits at the head until setup is finished
                if (!send_q_empty && (send_q_rd_data.cmd == SINGLE || setup_done)) begin
                    send_q_rd_req   = 1'b1;
                    dp.store_inputs = 1'b1;
                    state_next = (send_q_rd_data.cmd == BENCH) ? RD_APP_STATE : TX_MSG_REQ;
                end
            end
            RD_APP_STATE: begin
                state_rd_req = 1'b1;
                state_next   = WAIT_APP_STATE;
            end
            WAIT_APP_STATE: begin
                dp.store_app_state = 1'b1;
                state_next         = TX_MSG_REQ;
            end
            TX_MSG_REQ: begin
                ptr_req_val = 1'b1;
                if (ptr_req_rdy) begin
                    state_next = TX_MSG_NOTIF;
                end
            end
            TX_MSG_NOTIF: begin
                notif_rdy = 1'b1;
                if (notif_val) begin
                    dp.store_notif = 1'b1;
                    load_len       = 1'b1;
                    if (dp.cur_cmd == BENCH && dp.should_copy == FALSE) begin
                        state_next = BUMP_TAIL;
                    end else begin
                        state_next = TX_WR_MEM_REQ;
                    end
                end
            end
            TX_WR_MEM_REQ: begin
                buf_req_val = 1'b1;
                if (buf_req_rdy) begin
                    state_next = PAYLOAD_COPY;
                end
            end
            PAYLOAD_COPY: begin
                buf_data_val = 1'b1;
                if (buf_data_rdy) begin
                    decr = 1'b1;
                    if (last_wr) begin
                        state_next = WAIT_WR_RESP;
                    end
                end
            end
            WAIT_WR_RESP: begin
                buf_done_rdy = 1'b1;
                if (buf_done) begin
                    state_next = BUMP_TAIL;
                end
            end
            BUMP_TAIL: begin
                ptr_req_val    = 1'b1;
                dp.out_mux_sel = PTR_UPDATE;
                if (ptr_req_rdy) begin
                    state_next = UPDATE_FLOW;
                end
            end
            UPDATE_FLOW: begin
                if (dp.cur_cmd == BENCH) begin
                    state_wr_req  = 1'b1;
                    send_q_wr_req = !dp.last_pkt;
                end
                state_next = READY;
            end
            default: begin
                state_next = READY;
            end
        endcase
    end

    a_ptr_req_hold: assert property (
        @(posedge clk) disable iff (rst) ptr_req_val && !ptr_req_rdy |=> ptr_req_val
    );

endmodule

`default_nettype wire

//--- tx_engine_datap.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_engine_macros.svh"

module tx_engine_datap
    import tx_engine_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    tx_ctrl_datap_if.datap         dp,
    input  send_q_struct           send_q_rd_data,
    input  logic [`PKT_W-1:0]      rd_pkts,
    input  logic [`LEN_W-1:0]      offset,
    input  logic [`ADDR_W-1:0]     notif_addr,
    input  flag_e                  notif_copy,
    output ptr_req_struct          ptr_req_data,
    output logic [`ADDR_W-1:0]     buf_req_addr,
    output logic [`LEN_W-1:0]      buf_req_len,
    output logic [`DATA_W-1:0]     buf_data,
    output send_q_struct           send_q_wr_data,
    output logic [`FLOW_ID_W-1:0]  wr_flowid,
    output logic [`PKT_W-1:0]      wr_pkts,
    output logic [`LEN_W-1:0]      copy_len
);

    send_q_struct       cmd_reg;
    logic [`PKT_W-1:0]  pkts_reg;
    logic [`ADDR_W-1:0] addr_reg;
    logic [`LEN_W-1:0]  msg_len;

    // Command held for the whole message
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_reg <= '0;
        end else if (dp.store_inputs) begin
            cmd_reg <= send_q_rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (dp.store_app_state) begin
            pkts_reg <= rd_pkts;
        end
        if (dp.store_notif) begin
            addr_reg <= notif_addr;
        end
    end

    assign msg_len = (cmd_reg.cmd == BENCH) ? `LEN_W'(`BENCH_PKT_BYTES) : cmd_reg.length;

    assign ptr_req_data = '{kind: dp.out_mux_sel, flowid: cmd_reg.flowid, length: msg_len};
    assign buf_req_addr = addr_reg;
    assign buf_req_len  = msg_len;
    assign copy_len     = msg_len;

    // Flow id in the top byte and byte offset below
    assign buf_data = {8'(cmd_reg.flowid), 24'(offset)};

    assign send_q_wr_data = '{cmd: BENCH, flowid: cmd_reg.flowid, length: '0};
    assign wr_flowid      = cmd_reg.flowid;
    assign wr_pkts        = pkts_reg - `PKT_W'(1);

    assign dp.last_pkt    = (pkts_reg == `PKT_W'(1));
    assign dp.should_copy = notif_copy;
    assign dp.cur_cmd     = cmd_reg.cmd;

endmodule

`default_nettype wire

//--- tx_engine_macros.svh
`ifndef TX_ENGINE_MACROS_SVH
`define TX_ENGINE_MACROS_SVH

// Flow id space
`define FLOW_ID_W 2
`define NUM_FLOWS 4

// Payload and message sizing
`define DATA_W 32
`define LEN_W 16
`define ADDR_W 24
`define PKT_W 16

// Benchmark packets are always this many bytes
`define BENCH_PKT_BYTES 64

`define SEND_Q_DEPTH 8

`endif

//--- tx_engine_patterns.txt
// Tag in bits 31:28. 1 = setup: flow 17:16, budget 15:0
// 2 = command: BENCH 20, flow 17:16, length 15:0. 3 = notif: copy 24, addr 23:0
// f = expected pointer updates in 15:0
10010003
10020002
// BENCH first so it blocks the head until setup_done
20110000
20000010
20120000
20030008
// Notifications in message order
31001000
// SINGLE ignores the copy flag
30002000
30003000
31004000
30005000
31006000
31007000
// Flow 1 sends 3, flow 2 sends 2, plus two SINGLE
f0000007

//--- tx_engine_pkg.sv
`default_nettype none

`include "tx_engine_macros.svh"

package tx_engine_pkg;

    typedef enum logic {
        SINGLE = 1'b0,
        BENCH  = 1'b1
    } cmd_e;

    typedef enum logic {
        MSG_REQ    = 1'b0,
        PTR_UPDATE = 1'b1
    } ptr_kind_e;

    typedef enum logic {
        FALSE = 1'b0,
        TRUE  = 1'b1
    } flag_e;

    // Length only matters for SINGLE
    typedef struct packed {
        cmd_e                  cmd;
        logic [`FLOW_ID_W-1:0] flowid;
        logic [`LEN_W-1:0]     length;
    } send_q_struct;

    typedef struct packed {
        ptr_kind_e             kind;
        logic [`FLOW_ID_W-1:0] flowid;
        logic [`LEN_W-1:0]     length;
    } ptr_req_struct;

endpackage

`default_nettype wire

//--- tx_engine_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tx_engine_macros.svh"

module tx_engine_top
    import tx_engine_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_val,
    input  send_q_struct          cmd_data,
    output logic                  cmd_rdy,
    input  logic                  setup_val,
    input  logic [`FLOW_ID_W-1:0] setup_flowid,
    input  logic [`PKT_W-1:0]     setup_pkts,
    input  logic                  setup_done,
    output logic                  ptr_req_val,
    output ptr_req_struct         ptr_req_data,
    input  logic                  ptr_req_rdy,
    input  logic                  notif_val,
    input  logic [`ADDR_W-1:0]    notif_addr,
    input  flag_e                 notif_copy,
    output logic                  notif_rdy,
    output logic                  buf_req_val,
    output logic [`ADDR_W-1:0]    buf_req_addr,
    output logic [`LEN_W-1:0]     buf_req_len,
    input  logic                  buf_req_rdy,
    output logic                  buf_data_val,
    output logic [`DATA_W-1:0]    buf_data,
    input  logic                  buf_data_rdy,
    input  logic                  buf_done,
    output logic                  buf_done_rdy
);

    logic                  q_wr_req;
    send_q_struct          q_wr_data;
    logic                  fsm_wr_req;
    send_q_struct          fsm_wr_data;
    logic                  send_q_full;
    logic                  send_q_empty;
    logic                  send_q_rd_req;
    send_q_struct          send_q_rd_data;
    logic                  state_rd_req;
    logic                  state_wr_req;
    logic [`FLOW_ID_W-1:0] state_flowid;
    logic [`PKT_W-1:0]     state_wr_pkts;
    logic [`PKT_W-1:0]     state_rd_pkts;
    logic                  load_len;
    logic                  decr;
    logic                  last_wr;
    logic [`LEN_W-1:0]     copy_offset;
    logic [`LEN_W-1:0]     copy_len;

    tx_ctrl_datap_if dp_if ();

    // Re-enqueue from the FSM takes the write port first
    assign cmd_rdy   = !send_q_full && !fsm_wr_req;
    assign q_wr_req  = fsm_wr_req || (cmd_val && cmd_rdy);
    assign q_wr_data = fsm_wr_req ? fsm_wr_data : cmd_data;

    send_q_fifo u_send_q (
        .clk(clk), .rst(rst),
        .wr_req(q_wr_req), .wr_data(q_wr_data), .full(send_q_full),
        .rd_req(send_q_rd_req), .rd_data(send_q_rd_data), .empty(send_q_empty)
    );

    tx_app_state_mem u_app_state (
        .clk(clk), .rst(rst),
        .setup_val(setup_val), .setup_flowid(setup_flowid), .setup_pkts(setup_pkts),
        .rd_req(state_rd_req), .rd_flowid(state_flowid), .rd_pkts(state_rd_pkts),
        .wr_req(state_wr_req), .wr_flowid(state_flowid), .wr_pkts(state_wr_pkts)
    );

    tx_copy_counter u_copy_cnt (
        .clk(clk), .rst(rst),
        .load_len(load_len), .len(copy_len), .decr(decr),
        .last_wr(last_wr), .offset(copy_offset)
    );

    tx_engine_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .send_q_empty(send_q_empty), .send_q_rd_data(send_q_rd_data),
        .send_q_rd_req(send_q_rd_req), .send_q_wr_req(fsm_wr_req),
        .setup_done(setup_done),
        .ptr_req_val(ptr_req_val), .ptr_req_rdy(ptr_req_rdy),
        .notif_val(notif_val), .notif_rdy(notif_rdy),
        .buf_req_val(buf_req_val), .buf_req_rdy(buf_req_rdy),
        .buf_data_val(buf_data_val), .buf_data_rdy(buf_data_rdy),
        .buf_done(buf_done), .buf_done_rdy(buf_done_rdy),
        .state_rd_req(state_rd_req), .state_wr_req(state_wr_req),
        .load_len(load_len), .decr(decr), .last_wr(last_wr),
        .dp(dp_if.ctrl)
    );

    tx_engine_datap u_datap (
        .clk(clk), .rst(rst), .dp(dp_if.datap),
        .send_q_rd_data(send_q_rd_data), .rd_pkts(state_rd_pkts), .offset(copy_offset),
        .notif_addr(notif_addr), .notif_copy(notif_copy),
        .ptr_req_data(ptr_req_data), .buf_req_addr(buf_req_addr),
        .buf_req_len(buf_req_len), .buf_data(buf_data),
        .send_q_wr_data(fsm_wr_data), .wr_flowid(state_flowid), .wr_pkts(state_wr_pkts),
        .copy_len(copy_len)
    );

endmodule

`default_nettype wire
